// ==== hw/cdp_pkg.sv ====
package cdp_pkg;

	localparam int DATA_W = 8;
	localparam int REG_W = 16;
	localparam int RAM_ADDR_W = 8; // Only the low register bits reach the bus
	localparam int RAM_DEPTH = 256;

	localparam logic [3:0] RESET_P = 4'd0;
	localparam logic [3:0] RESET_X = 4'd0;

	// High nibble of the opcode
	typedef enum logic [3:0] {
		OP_IDL_LDN = 4'h0,
		OP_INC     = 4'h1,
		OP_DEC     = 4'h2,
		OP_BRANCH  = 4'h3,
		OP_LDA     = 4'h4,
		OP_STR     = 4'h5,
		OP_IO      = 4'h6,
		OP_MISC    = 4'h7,
		OP_GLO     = 4'h8,
		OP_GHI     = 4'h9,
		OP_PLO     = 4'ha,
		OP_PHI     = 4'hb,
		OP_LBR     = 4'hc,
		OP_SEP     = 4'hd,
		OP_SEX     = 4'he,
		OP_ALU     = 4'hf
	} major_op_e;

	// Low three bits of an Fx opcode, bit 3 picks the immediate form
	typedef enum logic [2:0] {
		ALU_LOAD, ALU_OR, ALU_AND, ALU_XOR, ALU_ADD, ALU_SD, ALU_SHIFT, ALU_SM
	} alu_op_e;

	typedef enum logic [2:0] {
		ST_HALT, ST_FETCH, ST_FETCH_WAIT, ST_EXEC, ST_MEM_WAIT
	} core_state_e;

endpackage

// ==== hw/cpu_alu.sv ====
`timescale 1ns/1ps

module cpu_alu import cdp_pkg::*; (
	input  alu_op_e           op,
	input  logic              shift_left,
	input  logic [DATA_W-1:0] d_in,
	input  logic              df_in,
	input  logic [DATA_W-1:0] operand,
	output logic [DATA_W-1:0] d_out,
	output logic              df_out
);

	logic [DATA_W:0] sum;
	logic [DATA_W:0] diff_sd;
	logic [DATA_W:0] diff_sm;

	assign sum = {1'b0, d_in} + {1'b0, operand};
	assign diff_sd = {1'b0, operand} - {1'b0, d_in}; // M - D
	assign diff_sm = {1'b0, d_in} - {1'b0, operand}; // D - M

	always_comb begin
		d_out = d_in;
		df_out = df_in;
		case (op)
			ALU_LOAD: d_out = operand;
			ALU_OR:   d_out = d_in | operand;
			ALU_AND:  d_out = d_in & operand;
			ALU_XOR:  d_out = d_in ^ operand;
			ALU_ADD: begin
				d_out = sum[DATA_W-1:0];
				df_out = sum[DATA_W]; // Carry
			end
			ALU_SD: begin
				d_out = diff_sd[DATA_W-1:0];
				df_out = ~diff_sd[DATA_W]; // DF set when no borrow
			end
			ALU_SM: begin
				d_out = diff_sm[DATA_W-1:0];
				df_out = ~diff_sm[DATA_W];
			end
			ALU_SHIFT: begin
				if (shift_left) begin
					d_out = {d_in[DATA_W-2:0], 1'b0};
					df_out = d_in[DATA_W-1];
				end else begin
					d_out = {1'b0, d_in[DATA_W-1:1]};
					df_out = d_in[0];
				end
			end
		endcase
	end

endmodule

// ==== hw/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core import cdp_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  run,
	input  logic                  cpu_ack,
	input  logic [DATA_W-1:0]     cpu_rdata,
	output logic                  cpu_req,
	output logic                  cpu_we,
	output logic [RAM_ADDR_W-1:0] cpu_addr,
	output logic [DATA_W-1:0]     cpu_wdata,
	output logic                  q,
	output logic                  idle
);

	logic [REG_W-1:0] regs [16];
	logic [3:0] p;
	logic [3:0] x;
	logic [DATA_W-1:0] d;
	logic df;
	logic [DATA_W-1:0] ir;
	core_state_e state;

	major_op_e major;
	alu_op_e alu_op;
	logic [3:0] n;
	logic branch_cond;
	logic take_branch;
	logic [DATA_W-1:0] alu_d;
	logic alu_df;

	// Memory side of the instruction in ir
	logic mem_go;
	logic mem_we;
	logic [3:0] mem_ptr;
	logic ptr_inc;

	assign major = major_op_e'(ir[7:4]);
	assign n = ir[3:0];
	assign alu_op = (major == OP_ALU) ? alu_op_e'(ir[2:0]) : ALU_LOAD; // LDN and LDA load D

	always_comb begin
		case (ir[2:0])
			3'd0:    branch_cond = 1'b1;
			3'd1:    branch_cond = q;
			3'd2:    branch_cond = (d == '0);
			3'd3:    branch_cond = df;
			default: branch_cond = 1'b0; // No EF lines
		endcase
	end

	assign take_branch = branch_cond ^ ir[3];

	always_comb begin
		mem_go = 1'b0;
		mem_we = 1'b0;
		mem_ptr = n;
		ptr_inc = 1'b0;
		case (major)
			OP_IDL_LDN: mem_go = (n != 4'd0);
			OP_BRANCH: begin
				mem_go = take_branch; // Target byte at R(P)
				mem_ptr = p;
			end
			OP_LDA: begin
				mem_go = 1'b1;
				ptr_inc = 1'b1;
			end
			OP_STR: begin
				mem_go = 1'b1;
				mem_we = 1'b1;
			end
			OP_ALU: begin
				if (alu_op != ALU_SHIFT) begin
					mem_go = 1'b1;
					mem_ptr = ir[3] ? p : x; // Immediate or M(R(X))
					ptr_inc = ir[3];
				end
			end
			default: ;
		endcase
	end

	cpu_alu i_cpu_alu (
		.op(alu_op),
		.shift_left(ir[3]),
		.d_in(d),
		.df_in(df),
		.operand(cpu_rdata),
		.d_out(alu_d),
		.df_out(alu_df)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_HALT;
			p <= RESET_P;
			x <= RESET_X;
			regs[RESET_P] <= '0;
			d <= '0;
			df <= 1'b0;
			q <= 1'b0;
			idle <= 1'b0;
			cpu_req <= 1'b0;
			cpu_we <= 1'b0;
			cpu_addr <= '0;
			cpu_wdata <= '0;
		end else begin
			case (state)
				ST_HALT: if (run && !idle) state <= ST_FETCH; // IDL holds until reset
				ST_FETCH: begin
					if (!run) begin
						state <= ST_HALT;
					end else begin
						cpu_req <= 1'b1;
						cpu_we <= 1'b0;
						cpu_addr <= regs[p][RAM_ADDR_W-1:0];
						regs[p] <= regs[p] + 1'b1;
						state <= ST_FETCH_WAIT;
					end
				end
				ST_FETCH_WAIT: begin
					if (cpu_ack) begin
						cpu_req <= 1'b0;
						ir <= cpu_rdata;
						state <= ST_EXEC;
					end
				end
				ST_EXEC: begin
					if (mem_go) begin
						cpu_req <= 1'b1;
						cpu_we <= mem_we;
						cpu_addr <= regs[mem_ptr][RAM_ADDR_W-1:0];
						cpu_wdata <= d;
						state <= ST_MEM_WAIT;
					end else begin
						state <= ST_FETCH;
					end
					if (ptr_inc)
						regs[mem_ptr] <= regs[mem_ptr] + 1'b1;
					case (major)
						OP_IDL_LDN: begin
							if (n == 4'd0) begin
								idle <= 1'b1;
								state <= ST_HALT;
							end
						end
						OP_INC:    regs[n] <= regs[n] + 1'b1;
						OP_DEC:    regs[n] <= regs[n] - 1'b1;
						OP_BRANCH: if (!take_branch) regs[p] <= regs[p] + 1'b1; // Skip target
						OP_MISC: begin
							if (n == 4'ha)
								q <= 1'b0; // REQ
							else if (n == 4'hb)
								q <= 1'b1; // SEQ
						end
						OP_GLO: d <= regs[n][DATA_W-1:0];
						OP_GHI: d <= regs[n][REG_W-1:DATA_W];
						OP_PLO: regs[n][DATA_W-1:0] <= d;
						OP_PHI: regs[n][REG_W-1:DATA_W] <= d;
						OP_SEP: p <= n;
						OP_SEX: x <= n;
						OP_ALU: begin
							if (alu_op == ALU_SHIFT) begin
								d <= alu_d;
								df <= alu_df;
							end
						end
						default: ; // 6x and Cx run as no-ops
					endcase
				end
				ST_MEM_WAIT: begin
					if (cpu_ack) begin
						cpu_req <= 1'b0;
						state <= ST_FETCH;
						if (major == OP_BRANCH) begin
							regs[p][DATA_W-1:0] <= cpu_rdata;
						end else if (!cpu_we) begin
							d <= alu_d;
							df <= alu_df;
						end
					end
				end
				default: state <= ST_HALT;
			endcase
		end
	end

endmodule

// ==== hw/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter import cdp_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  host_req,
	input  logic                  host_we,
	input  logic [RAM_ADDR_W-1:0] host_addr,
	input  logic [DATA_W-1:0]     host_wdata,
	input  logic                  cpu_req,
	input  logic                  cpu_we,
	input  logic [RAM_ADDR_W-1:0] cpu_addr,
	input  logic [DATA_W-1:0]     cpu_wdata,
	input  logic [DATA_W-1:0]     ram_rdata,
	output logic                  host_ack,
	output logic [DATA_W-1:0]     host_rdata,
	output logic                  cpu_ack,
	output logic [DATA_W-1:0]     cpu_rdata,
	output logic                  ram_en,
	output logic                  ram_we,
	output logic [RAM_ADDR_W-1:0] ram_addr,
	output logic [DATA_W-1:0]     ram_wdata
);

	logic host_gnt;
	logic cpu_gnt;

	// A master still holding req in its own ack cycle is not granted again
	assign host_gnt = host_req && !host_ack;
	assign cpu_gnt = cpu_req && !cpu_ack && !host_gnt; // Host has priority

	assign ram_en = host_gnt || cpu_gnt;
	assign ram_we = host_gnt ? host_we : (cpu_gnt && cpu_we);
	assign ram_addr = host_gnt ? host_addr : cpu_addr;
	assign ram_wdata = host_gnt ? host_wdata : cpu_wdata;

	// Ack flops also mark the owner of the access in flight
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			host_ack <= 1'b0;
			cpu_ack <= 1'b0;
		end else begin
			host_ack <= host_gnt;
			cpu_ack <= cpu_gnt;
		end
	end

	assign host_rdata = host_ack ? ram_rdata : '0;
	assign cpu_rdata = cpu_ack ? ram_rdata : '0;

endmodule

// ==== hw/scratch_ram.sv ====
`timescale 1ns/1ps

module scratch_ram import cdp_pkg::*; (
	input  logic                  clk,
	input  logic                  en,
	input  logic                  we,
	input  logic [RAM_ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0]     wdata,
	output logic [DATA_W-1:0]     rdata
);

	logic [DATA_W-1:0] mem [RAM_DEPTH];

	always_ff @(posedge clk) begin
		if (en) begin
			if (we)
				mem[addr] <= wdata;
			else
				rdata <= mem[addr]; // Valid in the ack cycle
		end
	end

endmodule

// ==== hw/cdp_top.sv ====
`timescale 1ns/1ps

module cdp_top import cdp_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  run,
	input  logic                  host_req,
	input  logic                  host_we,
	input  logic [RAM_ADDR_W-1:0] host_addr,
	input  logic [DATA_W-1:0]     host_wdata,
	output logic                  host_ack,
	output logic [DATA_W-1:0]     host_rdata,
	output logic                  q,
	output logic                  idle
);

	logic cpu_req;
	logic cpu_we;
	logic [RAM_ADDR_W-1:0] cpu_addr;
	logic [DATA_W-1:0] cpu_wdata;
	logic cpu_ack;
	logic [DATA_W-1:0] cpu_rdata;

	logic ram_en;
	logic ram_we;
	logic [RAM_ADDR_W-1:0] ram_addr;
	logic [DATA_W-1:0] ram_wdata;
	logic [DATA_W-1:0] ram_rdata;

	cpu_core i_cpu_core (
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.cpu_ack(cpu_ack),
		.cpu_rdata(cpu_rdata),
		.cpu_req(cpu_req),
		.cpu_we(cpu_we),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.q(q),
		.idle(idle)
	);

	mem_arbiter i_mem_arbiter (
		.clk(clk),
		.rst_n(rst_n),
		.host_req(host_req),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.cpu_req(cpu_req),
		.cpu_we(cpu_we),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.ram_rdata(ram_rdata),
		.host_ack(host_ack),
		.host_rdata(host_rdata),
		.cpu_ack(cpu_ack),
		.cpu_rdata(cpu_rdata),
		.ram_en(ram_en),
		.ram_we(ram_we),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata)
	);

	scratch_ram i_scratch_ram (
		.clk(clk),
		.en(ram_en),
		.we(ram_we),
		.addr(ram_addr),
		.wdata(ram_wdata),
		.rdata(ram_rdata)
	);

endmodule

// ==== dv/cdp_assertions.sv ====
`timescale 1ns/1ps

module cdp_assertions import cdp_pkg::*; (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  host_req,
	input logic                  host_we,
	input logic [RAM_ADDR_W-1:0] host_addr,
	input logic                  cpu_req,
	input logic                  cpu_we,
	input logic [RAM_ADDR_W-1:0] cpu_addr,
	input logic                  cpu_gnt,
	input logic                  host_ack,
	input logic                  cpu_ack,
	input logic                  ram_en,
	input logic                  ram_we,
	input logic [RAM_ADDR_W-1:0] ram_addr
);

	int failures = 0;

	// Only one access in flight
	one_grant: assert property (@(posedge clk) disable iff (!rst_n) !(host_ack && cpu_ack))
		else begin
			failures++;
			$error("both masters acknowledged in the same cycle");
		end

	// Host has priority, so it never waits
	host_ack_timing: assert property (@(posedge clk) disable iff (!rst_n)
		host_req && !host_ack |=> host_ack)
		else begin
			failures++;
			$error("host request not acknowledged one cycle after it was seen");
		end

	host_ack_source: assert property (@(posedge clk) disable iff (!rst_n)
		host_ack |-> $past(host_req && ram_en && ram_we == host_we && ram_addr == host_addr))
		else begin
			failures++;
			$error("host_ack without a host access on the RAM one cycle before");
		end

	cpu_ack_source: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_ack |-> $past(cpu_req && ram_en && ram_we == cpu_we && ram_addr == cpu_addr))
		else begin
			failures++;
			$error("cpu_ack without a core access on the RAM one cycle before");
		end

	// Waiting request, not yet granted
	cpu_hold: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_req && !cpu_gnt && !cpu_ack |=> $stable(cpu_addr) && $stable(cpu_we))
		else begin
			failures++;
			$error("core request changed while waiting for its grant");
		end

endmodule

// ==== dv/tb_cdp_top.sv ====
`timescale 1ns/1ps

module tb_cdp_top import cdp_pkg::*; ();

	localparam int DRIVE_DLY = 10;
	localparam int TEST_INSTRS = 700; // Rough count over all programs
	localparam int CYCLES_PER_INSTR = 200;
	localparam int MARGIN_CYCLES = 5000;

	logic clk;
	logic rst_n;
	logic run;
	logic host_req;
	logic host_we;
	logic [RAM_ADDR_W-1:0] host_addr;
	logic [DATA_W-1:0] host_wdata;
	logic host_ack;
	logic [DATA_W-1:0] host_rdata;
	logic q;
	logic idle;

	logic [16:0] lfsr_state = 17'd88854;
	logic [7:0] model [256]; // Expected RAM contents
	logic [7:0] prog [$];

	cdp_top i_cdp_top (
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.host_req(host_req),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_ack(host_ack),
		.host_rdata(host_rdata),
		.q(q),
		.idle(idle)
	);

	bind mem_arbiter cdp_assertions i_cdp_assertions (
		.clk(clk),
		.rst_n(rst_n),
		.host_req(host_req),
		.host_we(host_we),
		.host_addr(host_addr),
		.cpu_req(cpu_req),
		.cpu_we(cpu_we),
		.cpu_addr(cpu_addr),
		.cpu_gnt(cpu_gnt),
		.host_ack(host_ack),
		.cpu_ack(cpu_ack),
		.ram_en(ram_en),
		.ram_we(ram_we),
		.ram_addr(ram_addr)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Taps 17 and 14
	function automatic logic [7:0] lfsr_bits(input int width);
		logic [7:0] val;
		val = '0;
		for (int i = 0; i < width; i++) begin
			lfsr_state = {lfsr_state[15:0], lfsr_state[16] ^ lfsr_state[13]};
			val = {val[6:0], lfsr_state[0]};
		end
		return val;
	endfunction

	task automatic check_equal(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	task automatic step_cycle();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic reset_dut();
		run = 1'b0;
		host_req = 1'b0;
		rst_n = 1'b0;
		repeat (5) step_cycle();
		rst_n = 1'b1;
		step_cycle();
	endtask

	task automatic host_access(input logic we, input logic [7:0] addr, input logic [7:0] wdata,
			output logic [7:0] rdata);
		logic [7:0] cycles;
		cycles = '0;
		host_req = 1'b1;
		host_we = we;
		host_addr = addr;
		host_wdata = wdata;
		do begin
			step_cycle();
			cycles++;
		end while (!host_ack);
		rdata = host_rdata; // Valid in the ack cycle
		host_req = 1'b0;
		check_equal("host_ack latency", cycles, 8'd1);
		step_cycle();
	endtask

	task automatic host_write(input logic [7:0] addr, input logic [7:0] data);
		logic [7:0] unused;
		host_access(1'b1, addr, data, unused);
	endtask

	task automatic host_read(input logic [7:0] addr, output logic [7:0] data);
		host_access(1'b0, addr, 8'h00, data);
	endtask

	task automatic load_program();
		foreach (prog[i])
			host_write(8'(i), prog[i]);
	endtask

	task automatic wait_idle();
		while (!idle)
			step_cycle();
	endtask

	task automatic load_fresh();
		reset_dut();
		load_program();
	endtask

	task automatic run_to_idle();
		run = 1'b1;
		wait_idle();
		run = 1'b0;
	endtask

	task automatic test_host_ram();
		logic [7:0] addrs [16];
		logic [7:0] data;
		logic [7:0] rd;
		for (int i = 0; i < 16; i++) begin
			addrs[i] = lfsr_bits(8);
			data = lfsr_bits(8);
			model[addrs[i]] = data;
			host_write(addrs[i], data);
		end
		for (int i = 0; i < 16; i++) begin
			host_read(addrs[i], rd);
			check_equal("host_rdata", rd, model[addrs[i]]);
		end
	endtask

	// LDI a, op b, STR to F0, DF to F1 through BDF
	task automatic test_alu_imm();
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] op;
		logic [7:0] exp_d;
		logic exp_df;
		logic [7:0] rd;
		for (int k = 0; k < 12; k++) begin
			a = lfsr_bits(8);
			b = lfsr_bits(8);
			exp_df = 1'b0; // Reset value, kept by the logic ops
			case (k % 6)
				0: begin
					op = 8'hF9;
					exp_d = a | b;
				end
				1: begin
					op = 8'hFA;
					exp_d = a & b;
				end
				2: begin
					op = 8'hFB;
					exp_d = a ^ b;
				end
				3: begin
					op = 8'hFC;
					{exp_df, exp_d} = a + b;
				end
				4: begin
					op = 8'hFD; // SDI is M minus D
					exp_d = b - a;
					exp_df = (b >= a);
				end
				default: begin
					op = 8'hFF;
					exp_d = a - b;
					exp_df = (a >= b);
				end
			endcase
			prog = {8'hF8, 8'hF0, 8'hA2, 8'h90, 8'hB2, 8'hF8, a, op, b, 8'h52, 8'h12,
				8'hF8, 8'h00, 8'h33, 8'h11, 8'h30, 8'h13, 8'hF8, 8'h01, 8'h52, 8'h00};
			load_fresh();
			run_to_idle();
			host_read(8'hF0, rd);
			check_equal("D result", rd, exp_d);
			host_read(8'hF1, rd);
			check_equal("DF result", rd, {7'b0, exp_df});
		end
	endtask

	task automatic test_reg_copy();
		logic [7:0] table_data [4];
		logic [7:0] rd;
		prog = {8'h90, 8'hB3, 8'hB4, 8'hB5, 8'hA5, 8'hF8, 8'h80, 8'hA3, 8'hF8, 8'hA0, 8'hA4,
			8'h43, 8'h54, 8'h14, 8'h15, 8'h43, 8'h54, 8'h14, 8'h15,
			8'h03, 8'h54, 8'h14, 8'h15, 8'h13, 8'hE3, 8'hF0, 8'h54, 8'h14,
			8'h15, 8'h15, 8'h25, 8'h85, 8'hB6, 8'h90, 8'h96, 8'h54, 8'h00};
		load_fresh();
		for (int i = 0; i < 4; i++) begin
			table_data[i] = lfsr_bits(8);
			host_write(8'(8'h80 + i), table_data[i]);
		end
		run_to_idle();
		for (int i = 0; i < 4; i++) begin
			host_read(8'(8'hA0 + i), rd);
			check_equal("copied byte", rd, table_data[i]);
		end
		host_read(8'hA4, rd);
		check_equal("final count", rd, 8'd4);
	endtask

	task automatic test_branches();
		logic [7:0] n;
		logic [7:0] rd;
		n = lfsr_bits(4) + 8'd1;
		prog = {8'h90, 8'hB5, 8'hB6, 8'hA6, 8'hB7, 8'hF8, n, 8'hA5, 8'hF8, 8'hC0, 8'hA7,
			8'h16, 8'h25, 8'h85, 8'h3A, 8'h0B, 8'h86, 8'h57, 8'h17,
			8'h32, 8'h1B, 8'hF8, 8'h5A, 8'h33, 8'h1B, 8'h57, 8'h00, 8'h00};
		load_fresh();
		host_write(8'hC1, 8'h00);
		run_to_idle();
		host_read(8'hC0, rd);
		check_equal("loop iterations", rd, n);
		host_read(8'hC1, rd);
		check_equal("fall-through marker", rd, 8'h5A);
	endtask

	task automatic test_q_idle();
		logic [7:0] rd;
		prog = {8'h90, 8'hB8, 8'hB9, 8'hF8, 8'hD0, 8'hA8, 8'hF8, 8'h40, 8'hA9,
			8'h7B, 8'hF8, 8'hA5, 8'h58, 8'h29, 8'h89, 8'h3A, 8'h0D,
			8'h7A, 8'h18, 8'hF8, 8'h5C, 8'h58, 8'h00, 8'h18, 8'h58, 8'h00};
		load_fresh();
		host_write(8'hD0, 8'h00);
		host_write(8'hD1, 8'h00);
		host_write(8'hD2, 8'h00);
		check_equal("q", {7'b0, q}, 8'h00);
		run = 1'b1;
		do begin
			host_read(8'hD0, rd);
		end while (rd !== 8'hA5);
		check_equal("q", {7'b0, q}, 8'h01); // Delay loop keeps Q high here
		wait_idle();
		check_equal("q", {7'b0, q}, 8'h00);
		host_read(8'hD1, rd);
		check_equal("second marker", rd, 8'h5C);
		repeat (20) step_cycle();
		check_equal("idle", {7'b0, idle}, 8'h01);
		host_read(8'hD2, rd);
		check_equal("byte past IDL", rd, 8'h00);
		run = 1'b0;
	endtask

	task automatic test_contention();
		logic [7:0] rd;
		logic [7:0] addr;
		prog = {8'h90, 8'hBA, 8'hBB, 8'hF8, 8'hE0, 8'hAA, 8'hF8, 8'h10, 8'hAB,
			8'h8B, 8'h5A, 8'h1A, 8'h2B, 8'h8B, 8'h3A, 8'h09, 8'h00};
		load_fresh();
		for (int i = 0; i < 16; i++) begin
			model[8'h60 + i] = lfsr_bits(8);
			host_write(8'(8'h60 + i), model[8'h60 + i]);
		end
		run = 1'b1;
		while (!idle) begin
			addr = 8'h60 + lfsr_bits(4);
			host_read(addr, rd);
			check_equal("host_rdata", rd, model[addr]);
		end
		run = 1'b0;
		for (int k = 0; k < 16; k++) begin
			host_read(8'(8'hE0 + k), rd);
			check_equal("stored count", rd, 8'(16 - k));
		end
	endtask

	initial begin
		rst_n = 1'b0;
		run = 1'b0;
		host_req = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		reset_dut();
		test_host_ram();
		test_alu_imm();
		test_reg_copy();
		test_branches();
		test_q_idle();
		test_contention();
		if (i_cdp_top.i_mem_arbiter.i_cdp_assertions.failures == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		repeat (TEST_INSTRS * CYCLES_PER_INSTR + MARGIN_CYCLES) @(posedge clk);
		$display("ERROR: the run timed out before all tests finished");
		$display("FAIL: see errors above");
		$fatal(1);
	end

endmodule

// ==== build.f ====
hw/cdp_pkg.sv
hw/cpu_alu.sv
hw/cpu_core.sv
hw/mem_arbiter.sv
hw/scratch_ram.sv
hw/cdp_top.sv
dv/cdp_assertions.sv
dv/tb_cdp_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_cdp_top
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG ?= PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
